//--- files.f
src/axil_pkg.sv
src/xfcp_pkg.sv
src/xfcp_req_parser.sv
src/axil_access_engine.sv
src/xfcp_resp_buffer.sv
src/xfcp_axil_bridge.sv
tests/tb_axil_ram.sv
tests/xfcp_axil_tb.sv

//--- tests/xfcp_axil_tests.mem
// records: kind digit then byte; 0/1 drive (1 = last), 2/3 expect (3 = last), 5 back-pressure on
// 4 checks the memory word at the byte index against the next four bytes, msb first; f ends
// aligned 8-byte write at 0x04
0ff 012 000 000 000 004 000 008 011 022 033 044 055 066 077 188
2ff 213 200 200 200 204 200 308
// unaligned 5-byte read at 0x06
0ff 010 000 000 000 006 000 105
2ff 211 200 200 200 206 200 205 233 244 255 266 377
// words 1 and 2 in little-endian lane order, word 0 keeps its fill
401 044 033 022 011 402 088 077 066 055 400 080 040 0c0 000
// unaligned 3-byte write at 0x0D
0ff 012 000 000 000 00d 000 003 0b1 0b2 1b3
2ff 213 200 200 200 20d 200 303
// identify
0ff 1fe
2ff 2ff 201 280 220 200 220 200 208 200 210 200
200 200 200 200 200 200 241 258 249 24c 220 24d
261 273 274 265 272 200 200 200 200 300
// lane 0 of word 3 untouched
403 0b3 0b2 0b1 003
// back-pressure on, bad start byte and unknown type are dropped
500
0a5 010 000 000 000 000 000 101
0ff 055 000 000 000 000 000 000 101
// 4-byte read across words 3 and 4
0ff 010 000 000 000 00d 000 104
2ff 211 200 200 200 20d 200 204 2b1 2b2 2b3 304
f00

//--- tests/xfcp_axil_tb.sv
// testbench top: clock, reset, record-driven request packets, response and memory checks
module xfcp_axil_tb;

    localparam int timeout_cycles = 2000;
    localparam int max_recs = 512;
    localparam logic [31:0] seed_init = 32'h57d6_e529;

    logic            clk;
    logic            rst;
    xfcp_pkg::beat_t ds_beat;
    logic            ds_valid;
    logic            ds_ready;
    xfcp_pkg::beat_t us_beat;
    logic            us_valid;
    logic            us_ready;
    axil_pkg::addr_t awaddr;
    logic            awvalid;
    logic            awready;
    axil_pkg::data_t wdata;
    axil_pkg::strb_t wstrb;
    logic            wvalid;
    logic            wready;
    logic            bvalid;
    logic            bready;
    axil_pkg::addr_t araddr;
    logic            arvalid;
    logic            arready;
    axil_pkg::data_t rdata;
    logic            rvalid;
    logic            rready;

    // record = kind digit and a byte, see the data file
    logic [11:0]     recs [max_recs];
    xfcp_pkg::beat_t rx_q [$];
    integer          seed;
    logic            bp_en;
    int              rx_count;

    xfcp_axil_bridge dut (.*);

    tb_axil_ram #(.seed_init(seed_init)) ram (.*);

    always #4 clk = ~clk;

    // response sink, a beat counts when valid and ready meet at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (bp_en) begin
                us_ready = ($random(seed) & 1) != 0;
            end else begin
                us_ready = 1'b1;
            end
            if (us_valid && us_ready) begin
                rx_q.push_back(us_beat);
            end
        end
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error at time %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_beat(input xfcp_pkg::beat_t got, input xfcp_pkg::beat_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf(
                "Error at time %0t: response byte %0d is %02h last %b, expected %02h last %b",
                $time, rx_count, got.data, got.last, exp.data, exp.last));
        end
    endtask

    task automatic check_word(input axil_pkg::data_t got, input axil_pkg::data_t exp,
                              input int idx);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error at time %0t: memory word %0d is %08h, expected %08h",
                                        $time, idx, got, exp));
        end
    endtask

    // called on a falling edge, returns on the falling edge after the handshake
    task automatic drive_beat(input xfcp_pkg::beat_t b);
        int waited;
        waited = 0;
        ds_beat = b;
        ds_valid = 1'b1;
        while (!ds_ready) begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                stop_with_failure("request stream stalled, ds_ready never came back");
            end
        end
        @(negedge clk);
        ds_valid = 1'b0;
    endtask

    task automatic expect_beat(input xfcp_pkg::beat_t exp);
        int waited;
        xfcp_pkg::beat_t got;
        waited = 0;
        while (rx_q.size() == 0) begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                stop_with_failure("timed out waiting for a response byte");
            end
        end
        got = rx_q.pop_front();
        check_beat(got, exp);
        rx_count++;
    endtask

    task automatic run_records();
        int pos;
        logic [3:0] kind;
        logic [7:0] arg;
        xfcp_pkg::beat_t b;
        axil_pkg::data_t w;
        pos = 0;
        kind = recs[0][11:8];
        while (kind != 4'hf) begin
            arg = recs[pos][7:0];
            b.data = arg;
            b.last = kind[0];
            case (kind)
                4'h0, 4'h1: drive_beat(b);
                4'h2, 4'h3: expect_beat(b);
                4'h4: begin
                    // four bytes of the expected word follow, most significant first
                    w = {recs[pos+1][7:0], recs[pos+2][7:0], recs[pos+3][7:0], recs[pos+4][7:0]};
                    pos += 4;
                    check_word(ram.mem[arg[5:0]], w, int'(arg));
                end
                4'h5: bp_en = 1'b1;
                default: stop_with_failure("stimulus file holds an unknown record kind");
            endcase
            pos++;
            if (pos >= max_recs) begin
                stop_with_failure("stimulus file has no end record");
            end
            kind = recs[pos][11:8];
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        ds_beat = '0;
        ds_valid = 1'b0;
        us_ready = 1'b0;
        seed = seed_init;
        bp_en = 1'b0;
        rx_count = 0;
        for (int i = 0; i < max_recs; i++) begin
            recs[i] = 12'hf00;
        end
        $readmemh("tests/xfcp_axil_tests.mem", recs);
        if (recs[0] == 12'hf00) begin
            stop_with_failure("stimulus file is missing or empty");
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // bus and response side stay quiet with no request
        repeat (4) begin
            @(negedge clk);
            check_flag(us_valid, 1'b0, "us_valid");
            check_flag(awvalid, 1'b0, "awvalid");
            check_flag(wvalid, 1'b0, "wvalid");
            check_flag(arvalid, 1'b0, "arvalid");
            check_flag(bready, 1'b0, "bready");
            check_flag(rready, 1'b0, "rready");
        end
        check_flag(ds_ready, 1'b1, "ds_ready");

        run_records();

        if (rx_q.size() != 0) begin
            stop_with_failure("response stream sent bytes that no record expected");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- tests/tb_axil_ram.sv
// AXI-lite responder model with a 64-word memory and random ready delays
module tb_axil_ram #(
    parameter logic [31:0] seed_init = 32'h0
) (
    input  logic            clk,
    input  logic            rst,
    input  axil_pkg::addr_t awaddr,
    input  logic            awvalid,
    output logic            awready,
    input  axil_pkg::data_t wdata,
    input  axil_pkg::strb_t wstrb,
    input  logic            wvalid,
    output logic            wready,
    output logic            bvalid,
    input  logic            bready,
    input  axil_pkg::addr_t araddr,
    input  logic            arvalid,
    output logic            arready,
    output axil_pkg::data_t rdata,
    output logic            rvalid,
    input  logic            rready
);

    axil_pkg::data_t mem [64];
    integer          seed;
    logic            aw_done;
    logic            w_done;
    logic [5:0]      waddr;
    axil_pkg::data_t wdata_q;
    axil_pkg::strb_t wstrb_q;

    // every byte of the fill carries the word index
    initial begin
        seed = seed_init;
        // bus side quiet from time zero
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        arready = 1'b0;
        rdata = '0;
        rvalid = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {2'b10, 6'(i), 2'b01, 6'(i), 2'b11, 6'(i), 2'b00, 6'(i)};
        end
    end

    // ready offered on about half the cycles
    function automatic logic coin();
        return ($random(seed) & 1) != 0;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
            aw_done <= 1'b0;
            w_done <= 1'b0;
        end else begin
            awready <= awvalid && !awready && !aw_done && coin();
            wready <= wvalid && !wready && !w_done && coin();
            if (awvalid && awready) begin
                aw_done <= 1'b1;
                waddr <= awaddr[7:2];
            end
            if (wvalid && wready) begin
                w_done <= 1'b1;
                wdata_q <= wdata;
                wstrb_q <= wstrb;
            end
            // commit the strobed lanes once both halves are in
            if (aw_done && w_done) begin
                for (int i = 0; i < 4; i++) begin
                    if (wstrb_q[i]) begin
                        mem[waddr][8*i +: 8] <= wdata_q[8*i +: 8];
                    end
                end
                aw_done <= 1'b0;
                w_done <= 1'b0;
                bvalid <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            arready <= arvalid && !arready && !rvalid && coin();
            if (arvalid && arready) begin
                rdata <= mem[araddr[7:2]];
                rvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

//--- src/xfcp_axil_bridge.sv
// XFCP to AXI-lite bridge top: parser, access engine and response buffer
module xfcp_axil_bridge (
    input  logic            clk,
    input  logic            rst,
    // request stream
    input  xfcp_pkg::beat_t ds_beat,
    input  logic            ds_valid,
    output logic            ds_ready,
    // response stream
    output xfcp_pkg::beat_t us_beat,
    output logic            us_valid,
    input  logic            us_ready,
    // AXI-lite write channels
    output axil_pkg::addr_t awaddr,
    output logic            awvalid,
    input  logic            awready,
    output axil_pkg::data_t wdata,
    output axil_pkg::strb_t wstrb,
    output logic            wvalid,
    input  logic            wready,
    input  logic            bvalid,
    output logic            bready,
    // AXI-lite read channels
    output axil_pkg::addr_t araddr,
    output logic            arvalid,
    input  logic            arready,
    input  axil_pkg::data_t rdata,
    input  logic            rvalid,
    output logic            rready
);

    xfcp_pkg::req_t  req;
    logic            req_valid;
    logic            req_ready;
    xfcp_pkg::beat_t pay_beat;
    logic            pay_valid;
    logic            pay_ready;
    xfcp_pkg::beat_t rsp_beat;
    logic            rsp_valid;
    logic            rsp_ready;

    xfcp_req_parser parser (.*);

    axil_access_engine engine (.*);

    xfcp_resp_buffer resp_buffer (.*);

endmodule

//--- src/xfcp_resp_buffer.sv
// response skid buffer: registered output beat plus one temporary entry
module xfcp_resp_buffer (
    input  logic            clk,
    input  logic            rst,
    input  xfcp_pkg::beat_t rsp_beat,
    input  logic            rsp_valid,
    output logic            rsp_ready,
    output xfcp_pkg::beat_t us_beat,
    output logic            us_valid,
    input  logic            us_ready
);

    xfcp_pkg::beat_t tmp_beat;
    logic            tmp_valid;
    logic            in_fire;

    // accept whenever the temporary entry is free
    assign rsp_ready = !tmp_valid;
    assign in_fire = rsp_valid && rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            us_valid <= 1'b0;
            tmp_valid <= 1'b0;
        end else if (!us_valid || us_ready) begin
            // output register free after this edge
            if (tmp_valid) begin
                // older beat goes first, input is blocked meanwhile
                us_beat <= tmp_beat;
                us_valid <= 1'b1;
                tmp_valid <= 1'b0;
            end else begin
                us_beat <= rsp_beat;
                us_valid <= in_fire;
            end
        end else if (in_fire) begin
            // output stalled, park the new beat
            tmp_beat <= rsp_beat;
            tmp_valid <= 1'b1;
        end
    end

endmodule

//--- src/axil_access_engine.sv
// access engine: AXI-lite reads and writes, response header, read data and identity bytes
module axil_access_engine (
    input  logic            clk,
    input  logic            rst,
    input  xfcp_pkg::req_t  req,
    input  logic            req_valid,
    output logic            req_ready,
    input  xfcp_pkg::beat_t pay_beat,
    input  logic            pay_valid,
    output logic            pay_ready,
    output xfcp_pkg::beat_t rsp_beat,
    output logic            rsp_valid,
    input  logic            rsp_ready,
    output axil_pkg::addr_t awaddr,
    output logic            awvalid,
    input  logic            awready,
    output axil_pkg::data_t wdata,
    output axil_pkg::strb_t wstrb,
    output logic            wvalid,
    input  logic            wready,
    input  logic            bvalid,
    output logic            bready,
    output axil_pkg::addr_t araddr,
    output logic            arvalid,
    input  logic            arready,
    input  axil_pkg::data_t rdata,
    input  logic            rvalid,
    output logic            rready
);

    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_wdata,
        st_wresp,
        st_rwait,
        st_rsend,
        st_id
    } state_t;

    state_t          state;
    xfcp_pkg::req_t  rq;
    axil_pkg::addr_t addr;
    axil_pkg::data_t word;
    axil_pkg::strb_t strb;
    axil_pkg::lane_t lane;
    logic [15:0]     rem;
    logic [4:0]      idx;
    logic            rsp_fire;
    logic            pay_fire;

    assign req_ready = (state == st_idle);
    assign pay_ready = (state == st_wdata);
    assign rsp_fire = rsp_valid && rsp_ready;
    assign pay_fire = pay_valid && pay_ready;

    // one word address serves both channels
    assign awaddr = addr;
    assign araddr = addr;
    assign wdata = word;
    assign wstrb = strb;

    always_comb begin
        rsp_beat = '0;
        rsp_valid = 1'b0;
        case (state)
            st_header: begin
                rsp_valid = 1'b1;
                case (idx[2:0])
                    3'd0: rsp_beat.data = xfcp_pkg::start_tag;
                    3'd1: rsp_beat.data = (rq.op == xfcp_pkg::op_read) ? xfcp_pkg::read_resp :
                                          (rq.op == xfcp_pkg::op_write) ? xfcp_pkg::write_resp :
                                          xfcp_pkg::id_resp;
                    3'd2: rsp_beat.data = rq.addr[31:24];
                    3'd3: rsp_beat.data = rq.addr[23:16];
                    3'd4: rsp_beat.data = rq.addr[15:8];
                    3'd5: rsp_beat.data = rq.addr[7:0];
                    3'd6: rsp_beat.data = rq.count[15:8];
                    default: rsp_beat.data = rq.count[7:0];
                endcase
                // writes and empty reads end with the header
                rsp_beat.last = (idx == 5'd7) && (rq.op == xfcp_pkg::op_write || rem == 16'd0);
            end
            st_rsend: begin
                rsp_valid = 1'b1;
                rsp_beat.data = word[8*lane +: 8];
                rsp_beat.last = (rem == 16'd1);
            end
            st_id: begin
                rsp_valid = 1'b1;
                rsp_beat.data = xfcp_pkg::id_rom[idx];
                rsp_beat.last = (idx == 5'(xfcp_pkg::id_len - 1));
            end
            default: begin
                rsp_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        rq <= req;
                        // bus works on aligned words, low bits pick the first lane
                        addr <= {req.addr[31:2], 2'b00};
                        lane <= req.addr[1:0];
                        rem <= req.count;
                        idx <= 5'd0;
                        word <= '0;
                        strb <= '0;
                        state <= st_header;
                    end
                end
                st_header: begin
                    if (rsp_fire) begin
                        idx <= idx + 5'd1;
                        if (rq.op == xfcp_pkg::op_id && idx == 5'd1) begin
                            idx <= 5'd0;
                            state <= st_id;
                        end else if (idx == 5'd7) begin
                            if (rem == 16'd0) begin
                                state <= st_idle;
                            end else if (rq.op == xfcp_pkg::op_write) begin
                                state <= st_wdata;
                            end else begin
                                arvalid <= 1'b1;
                                rready <= 1'b1;
                                state <= st_rwait;
                            end
                        end
                    end
                end
                st_wdata: begin
                    if (pay_fire) begin
                        word[8*lane +: 8] <= pay_beat.data;
                        strb[lane] <= 1'b1;
                        lane <= lane + 2'd1;
                        rem <= rem - 16'd1;
                        if (lane == 2'd3 || rem == 16'd1 || pay_beat.last) begin
                            // early end of packet leaves nothing more to write
                            if (pay_beat.last) begin
                                rem <= 16'd0;
                            end
                            awvalid <= 1'b1;
                            wvalid <= 1'b1;
                            bready <= 1'b1;
                            state <= st_wresp;
                        end
                    end
                end
                st_wresp: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (bvalid && bready) begin
                        bready <= 1'b0;
                        addr <= addr + axil_pkg::word_step;
                        word <= '0;
                        strb <= '0;
                        state <= (rem == 16'd0) ? st_idle : st_wdata;
                    end
                end
                st_rwait: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                    end
                    if (rvalid && rready) begin
                        rready <= 1'b0;
                        word <= rdata;
                        state <= st_rsend;
                    end
                end
                st_rsend: begin
                    if (rsp_fire) begin
                        rem <= rem - 16'd1;
                        lane <= lane + 2'd1;
                        if (rem == 16'd1) begin
                            state <= st_idle;
                        end else if (lane == 2'd3) begin
                            // word used up, fetch the next one
                            addr <= addr + axil_pkg::word_step;
                            arvalid <= 1'b1;
                            rready <= 1'b1;
                            state <= st_rwait;
                        end
                    end
                end
                st_id: begin
                    if (rsp_fire) begin
                        idx <= idx + 5'd1;
                        if (idx == 5'(xfcp_pkg::id_len - 1)) begin
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- src/xfcp_req_parser.sv
// request parser: start tag and type check, header decode, write payload forwarding
module xfcp_req_parser (
    input  logic            clk,
    input  logic            rst,
    input  xfcp_pkg::beat_t ds_beat,
    input  logic            ds_valid,
    output logic            ds_ready,
    output xfcp_pkg::req_t  req,
    output logic            req_valid,
    input  logic            req_ready,
    output xfcp_pkg::beat_t pay_beat,
    output logic            pay_valid,
    input  logic            pay_ready
);

    typedef enum logic [2:0] {
        st_idle,
        st_type,
        st_header,
        st_payload,
        st_discard
    } state_t;

    state_t      state;
    logic [2:0]  hdr_cnt;
    logic [15:0] rem;
    logic [15:0] cnt_next;
    logic        ds_fire;

    // hold off input while a request or payload byte is still pending
    assign ds_ready = !req_valid && (!pay_valid || pay_ready);
    assign ds_fire = ds_valid && ds_ready;

    // count field once the current byte has been shifted in
    assign cnt_next = {req.count[7:0], ds_beat.data};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            req_valid <= 1'b0;
            pay_valid <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            if (pay_valid && pay_ready) begin
                pay_valid <= 1'b0;
            end

            if (ds_fire) begin
                case (state)
                    st_idle: begin
                        if (ds_beat.last) begin
                            state <= st_idle;
                        end else if (ds_beat.data == xfcp_pkg::start_tag) begin
                            state <= st_type;
                        end else begin
                            state <= st_discard;
                        end
                    end
                    st_type: begin
                        hdr_cnt <= 3'd0;
                        if (ds_beat.data == xfcp_pkg::id_req) begin
                            // no header, answer right away
                            req.op <= xfcp_pkg::op_id;
                            req_valid <= 1'b1;
                            state <= ds_beat.last ? st_idle : st_discard;
                        end else if (ds_beat.last) begin
                            state <= st_idle;
                        end else if (ds_beat.data == xfcp_pkg::read_req) begin
                            req.op <= xfcp_pkg::op_read;
                            state <= st_header;
                        end else if (ds_beat.data == xfcp_pkg::write_req) begin
                            req.op <= xfcp_pkg::op_write;
                            state <= st_header;
                        end else begin
                            state <= st_discard;
                        end
                    end
                    st_header: begin
                        {req.addr, req.count} <= {req.addr[23:0], req.count, ds_beat.data};
                        hdr_cnt <= hdr_cnt + 3'd1;
                        if (hdr_cnt == 3'(xfcp_pkg::hdr_bytes - 1)) begin
                            rem <= cnt_next;
                            if (req.op != xfcp_pkg::op_write) begin
                                req_valid <= 1'b1;
                                state <= ds_beat.last ? st_idle : st_discard;
                            end else if (ds_beat.last) begin
                                // a write with its payload missing is dropped
                                req_valid <= (cnt_next == 16'd0);
                                state <= st_idle;
                            end else begin
                                req_valid <= 1'b1;
                                state <= (cnt_next == 16'd0) ? st_discard : st_payload;
                            end
                        end else if (ds_beat.last) begin
                            // truncated header
                            state <= st_idle;
                        end
                    end
                    st_payload: begin
                        pay_beat <= ds_beat;
                        pay_valid <= 1'b1;
                        rem <= rem - 16'd1;
                        if (ds_beat.last) begin
                            state <= st_idle;
                        end else if (rem == 16'd1) begin
                            // count reached, drop the rest of the packet
                            state <= st_discard;
                        end
                    end
                    st_discard: begin
                        if (ds_beat.last) begin
                            state <= st_idle;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

endmodule

//--- src/xfcp_pkg.sv
// XFCP protocol tags and type codes, stream beat, request struct, identity block
package xfcp_pkg;

    // framing
    localparam logic [7:0] start_tag = 8'hff;

    // request and response type codes
    localparam logic [7:0] read_req   = 8'h10;
    localparam logic [7:0] read_resp  = 8'h11;
    localparam logic [7:0] write_req  = 8'h12;
    localparam logic [7:0] write_resp = 8'h13;
    localparam logic [7:0] id_req     = 8'hfe;
    localparam logic [7:0] id_resp    = 8'hff;

    // 4 address bytes then 2 count bytes, both big-endian
    localparam int hdr_bytes = 6;
    localparam int id_len = 32;

    // one byte on a request or response stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } beat_t;

    typedef enum logic [1:0] {
        op_read,
        op_write,
        op_id
    } op_t;

    // decoded request header
    typedef struct packed {
        op_t             op;
        axil_pkg::addr_t addr;
        logic [15:0]     count;
    } req_t;

    // identity block, 16-bit fields are little-endian
    localparam logic [7:0] id_rom [id_len] = '{
        8'h01, 8'h80,
        8'(axil_pkg::addr_w), 8'h00,
        8'(axil_pkg::data_w), 8'h00,
        8'd8, 8'h00,
        8'd16, 8'h00,
        8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
        // name string starts at offset 16
        "A", "X", "I", "L", " ", "M", "a", "s", "t", "e", "r",
        8'h00, 8'h00, 8'h00, 8'h00, 8'h00
    };

endpackage

//--- src/axil_pkg.sv
// AXI-lite bus widths, word types and byte lane helpers
package axil_pkg;

    // bus geometry
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // byte address
    typedef logic [addr_w-1:0] addr_t;

    // one full data word, lane 0 in the low byte
    typedef logic [data_w-1:0] data_t;

    // one strobe bit per byte lane
    typedef logic [strb_w-1:0] strb_t;

    // byte lane index within a word, also the low address bits
    typedef logic [$clog2(strb_w)-1:0] lane_t;

    // distance between two aligned words
    localparam addr_t word_step = addr_t'(strb_w);

endpackage
